// ==== source/axis_pkg.sv ====
package axis_pkg;

    // ========================================================================
    // Stream sideband types
    // ========================================================================

    // Source and destination port numbers, carried in tid and tdest
    typedef logic [3:0] port_t;

    // Hash on the way in, queue ID on the way out
    typedef logic [11:0] rss_entropy_t;

    // User sideband
    typedef struct packed {
        logic         rss_enable;
        rss_entropy_t rss_entropy;
    } tuser_meta_t;

    // Everything that rides next to tdata and tkeep
    typedef struct packed {
        logic        tlast;
        port_t       tid;
        port_t       tdest;
        tuser_meta_t tuser;
    } axis_meta_t;

endpackage : axis_pkg

// ==== source/hash2qid_pkg.sv ====
package hash2qid_pkg;

    // ========================================================================
    // Queue ID and table geometry
    // ========================================================================

    typedef logic [11:0] qid_t;

    // Function select from entropy bits 11..10, 0 is the PF
    typedef logic [1:0] func_id_t;

    // Entry index from entropy bits 6..0
    typedef logic [6:0] entry_idx_t;

    // Function in the top two bits, entry below
    typedef logic [8:0] table_addr_t;

    localparam int NUM_FUNCS   = 4;
    localparam int TABLE_DEPTH = 128;

    // ========================================================================
    // Register map, word addressed
    // ========================================================================

    typedef logic [9:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // One base queue word per function
    localparam reg_addr_t REG_QCONFIG_BASE = 10'd0;
    // Function t entry j lives at REG_TABLE_BASE + t*TABLE_DEPTH + j
    localparam reg_addr_t REG_TABLE_BASE   = 10'd512;

    typedef struct packed {
        logic        wr_en;
        table_addr_t addr;
        qid_t        qid;
    } table_wr_t;

endpackage : hash2qid_pkg

// ==== source/hash2qid_regs.sv ====
`timescale 1ns/1ps

module hash2qid_regs (
    input  logic                                             core_clk,
    input  logic                                             rst,
    input  logic                                             reg_wr,
    input  hash2qid_pkg::reg_addr_t                          reg_addr,
    input  hash2qid_pkg::reg_data_t                          reg_wdata,
    output hash2qid_pkg::table_wr_t                          table_wr,
    output hash2qid_pkg::qid_t [hash2qid_pkg::NUM_FUNCS-1:0] base_qid
);

    logic                    qcfg_we;
    logic                    table_we;
    hash2qid_pkg::reg_addr_t wr_addr;
    hash2qid_pkg::reg_data_t wr_data;
    hash2qid_pkg::func_id_t  qcfg_func;

    // ========================================================================
    // Address decode
    // ========================================================================

    function automatic logic is_qcfg(input hash2qid_pkg::reg_addr_t addr);
        hash2qid_pkg::reg_addr_t offs;
        offs = addr - hash2qid_pkg::REG_QCONFIG_BASE;
        return offs < hash2qid_pkg::reg_addr_t'(hash2qid_pkg::NUM_FUNCS);
    endfunction

    // Offset wraps high for addresses below the table window
    function automatic logic is_table(input hash2qid_pkg::reg_addr_t addr);
        hash2qid_pkg::reg_addr_t offs;
        offs = addr - hash2qid_pkg::REG_TABLE_BASE;
        return offs < hash2qid_pkg::reg_addr_t'(hash2qid_pkg::NUM_FUNCS
                                                * hash2qid_pkg::TABLE_DEPTH);
    endfunction

    // Decoded strobes, one cycle after the write
    always_ff @(posedge core_clk) begin
        if (rst) begin
            qcfg_we  <= 1'b0;
            table_we <= 1'b0;
        end else begin
            qcfg_we  <= reg_wr && is_qcfg(reg_addr);
            table_we <= reg_wr && is_table(reg_addr);
        end
    end

    // Write payload, captured with the strobe
    always_ff @(posedge core_clk) begin
        if (reg_wr) begin
            wr_addr <= reg_addr;
            wr_data <= reg_wdata;
        end
    end

    // ========================================================================
    // Base queue registers and table write command
    // ========================================================================

    assign qcfg_func = hash2qid_pkg::func_id_t'(wr_addr - hash2qid_pkg::REG_QCONFIG_BASE);

    always_ff @(posedge core_clk) begin
        if (rst) begin
            base_qid <= '0;
        end else if (qcfg_we) begin
            base_qid[qcfg_func] <= hash2qid_pkg::qid_t'(wr_data);
        end
    end

    always_comb begin
        table_wr.wr_en = table_we;
        table_wr.addr  = hash2qid_pkg::table_addr_t'(wr_addr - hash2qid_pkg::REG_TABLE_BASE);
        table_wr.qid   = hash2qid_pkg::qid_t'(wr_data);
    end

    // Words 4..511 are not mapped
    a_reg_addr_defined: assert property (@(posedge core_clk) disable iff (rst)
        reg_wr |-> (is_qcfg(reg_addr) || is_table(reg_addr)))
        else $error("Write to undefined register word %0d", reg_addr);

endmodule : hash2qid_regs

// ==== source/hash2qid_table.sv ====
`timescale 1ns/1ps

module hash2qid_table (
    input  logic                      core_clk,
    input  hash2qid_pkg::table_wr_t   table_wr,
    input  logic                      rd_en,
    input  hash2qid_pkg::table_addr_t rd_addr,
    output hash2qid_pkg::qid_t        rd_qid
);

    localparam int ENTRIES = hash2qid_pkg::NUM_FUNCS * hash2qid_pkg::TABLE_DEPTH;

    // ========================================================================
    // Queue offset storage for PF and the three VFs
    // ========================================================================

    hash2qid_pkg::qid_t mem [ENTRIES];

    // Write port, fed from the register block
    always_ff @(posedge core_clk) begin
        if (table_wr.wr_en) begin
            mem[table_wr.addr] <= table_wr.qid;
        end
    end

    // Read port, one cycle latency
    // Same-address write in the same cycle gives the old entry
    always_ff @(posedge core_clk) begin
        if (rd_en) begin
            rd_qid <= mem[rd_addr];
        end
    end

endmodule : hash2qid_table

// ==== source/hash2qid_lookup.sv ====
`timescale 1ns/1ps

module hash2qid_lookup #(
    parameter int DATA_BYTE_WID = 8
) (
    input  logic                                             core_clk,
    input  logic                                             rst,
    input  logic                                             in_valid,
    output logic                                             in_ready,
    input  logic [DATA_BYTE_WID*8-1:0]                       in_data,
    input  logic [DATA_BYTE_WID-1:0]                         in_keep,
    input  axis_pkg::axis_meta_t                             in_meta,
    input  hash2qid_pkg::qid_t [hash2qid_pkg::NUM_FUNCS-1:0] base_qid,
    output logic                                             rd_en,
    output hash2qid_pkg::table_addr_t                        rd_addr,
    input  hash2qid_pkg::qid_t                               rd_qid,
    output logic                                             out_valid,
    input  logic                                             out_ready,
    output logic [DATA_BYTE_WID*8-1:0]                       out_data,
    output logic [DATA_BYTE_WID-1:0]                         out_keep,
    output axis_pkg::axis_meta_t                             out_meta
);

    logic                       s1_valid;
    logic [DATA_BYTE_WID*8-1:0] s1_data;
    logic [DATA_BYTE_WID-1:0]   s1_keep;
    axis_pkg::axis_meta_t       s1_meta;
    logic                       s1_en;
    logic                       s2_en;
    hash2qid_pkg::func_id_t     in_func;
    hash2qid_pkg::entry_idx_t   in_entry;
    hash2qid_pkg::func_id_t     s1_func;
    hash2qid_pkg::qid_t         s1_base;
    hash2qid_pkg::qid_t         s1_qid;
    axis_pkg::axis_meta_t       s1_meta_new;

    // Stage 2 moves when empty or drained, stage 1 also fills a bubble
    assign s2_en    = !out_valid || out_ready;
    assign s1_en    = !s1_valid || s2_en;
    assign in_ready = s1_en;

    // ========================================================================
    // Stage 1: accept beat, issue table read
    // ========================================================================

    assign in_func  = in_meta.tuser.rss_entropy[11:10];
    assign in_entry = in_meta.tuser.rss_entropy[6:0];
    assign rd_addr  = {in_func, in_entry};
    // Read only with a stage 1 load so rd_qid stays with the held beat
    assign rd_en    = s1_en;

    always_ff @(posedge core_clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (s1_en) begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge core_clk) begin
        if (s1_en) begin
            s1_data <= in_data;
            s1_keep <= in_keep;
            s1_meta <= in_meta;
        end
    end

    // ========================================================================
    // Stage 2: base plus entry, rewrite metadata
    // ========================================================================

    assign s1_func = s1_meta.tuser.rss_entropy[11:10];
    assign s1_base = base_qid[s1_func];
    assign s1_qid  = s1_meta.tuser.rss_enable ? s1_base + rd_qid : s1_base;

    always_comb begin
        s1_meta_new                   = s1_meta;
        s1_meta_new.tuser.rss_enable  = 1'b1;
        s1_meta_new.tuser.rss_entropy = s1_qid;
    end

    always_ff @(posedge core_clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (s2_en) begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge core_clk) begin
        if (s2_en) begin
            out_data <= s1_data;
            out_keep <= s1_keep;
            out_meta <= s1_meta_new;
        end
    end

    // Held beat must not change under back-pressure
    a_out_stable: assert property (@(posedge core_clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_keep)
            && $stable(out_meta))
        else $error("Output beat changed while stalled");

    a_out_idle_after_rst: assert property (@(posedge core_clk) rst |=> !out_valid)
        else $error("out_valid set right after reset");

endmodule : hash2qid_lookup

// ==== source/hash2qid_top.sv ====
`timescale 1ns/1ps

module hash2qid #(
    parameter int DATA_BYTE_WID = 8
) (
    input  logic                       core_clk,
    input  logic                       rst,
    // Register write port
    input  logic                       reg_wr,
    input  hash2qid_pkg::reg_addr_t    reg_addr,
    input  hash2qid_pkg::reg_data_t    reg_wdata,
    // Input stream
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [DATA_BYTE_WID*8-1:0] in_data,
    input  logic [DATA_BYTE_WID-1:0]   in_keep,
    input  axis_pkg::axis_meta_t       in_meta,
    // Output stream
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [DATA_BYTE_WID*8-1:0] out_data,
    output logic [DATA_BYTE_WID-1:0]   out_keep,
    output axis_pkg::axis_meta_t       out_meta
);

    hash2qid_pkg::table_wr_t                          table_wr;
    hash2qid_pkg::qid_t [hash2qid_pkg::NUM_FUNCS-1:0] base_qid;
    logic                                             rd_en;
    hash2qid_pkg::table_addr_t                        rd_addr;
    hash2qid_pkg::qid_t                               rd_qid;

    hash2qid_regs regs0 (
        .core_clk,
        .rst,
        .reg_wr,
        .reg_addr,
        .reg_wdata,
        .table_wr,
        .base_qid
    );

    hash2qid_table table0 (
        .core_clk,
        .table_wr,
        .rd_en,
        .rd_addr,
        .rd_qid
    );

    hash2qid_lookup #(
        .DATA_BYTE_WID (DATA_BYTE_WID)
    ) lookup0 (
        .core_clk,
        .rst,
        .in_valid,
        .in_ready,
        .in_data,
        .in_keep,
        .in_meta,
        .base_qid,
        .rd_en,
        .rd_addr,
        .rd_qid,
        .out_valid,
        .out_ready,
        .out_data,
        .out_keep,
        .out_meta
    );

endmodule : hash2qid

// ==== test/hash2qid_checker.sv ====
`timescale 1ns/1ps

module hash2qid_checker #(
    parameter int DATA_BYTE_WID = 8
) (
    input  logic                       core_clk,
    input  logic                       rst,
    input  int                         test_id,
    input  logic                       reg_wr,
    input  hash2qid_pkg::reg_addr_t    reg_addr,
    input  hash2qid_pkg::reg_data_t    reg_wdata,
    input  logic                       in_valid,
    input  logic                       in_ready,
    input  logic [DATA_BYTE_WID*8-1:0] in_data,
    input  logic [DATA_BYTE_WID-1:0]   in_keep,
    input  axis_pkg::axis_meta_t       in_meta,
    input  logic                       out_valid,
    input  logic                       out_ready,
    input  logic [DATA_BYTE_WID*8-1:0] out_data,
    input  logic [DATA_BYTE_WID-1:0]   out_keep,
    input  axis_pkg::axis_meta_t       out_meta,
    output int                         errors,
    output int                         pending
);

    hash2qid_pkg::qid_t         shadow_base [4];
    hash2qid_pkg::qid_t         shadow_table [512];
    logic [DATA_BYTE_WID*8-1:0] data_q [$];
    logic [DATA_BYTE_WID-1:0]   keep_q [$];
    axis_pkg::axis_meta_t       meta_q [$];
    logic                       rst_d;
    logic                       stalled;
    logic [DATA_BYTE_WID*8-1:0] held_data;
    logic [DATA_BYTE_WID-1:0]   held_keep;
    axis_pkg::axis_meta_t       held_meta;

    function automatic string test_name(input int id);
        case (id)
            0:       return "reset";
            1:       return "rss_on_stream";
            2:       return "rss_off_stream";
            3:       return "backpressure";
            default: return "reprogram";
        endcase
    endfunction

    // Expected output sideband from the input beat and the shadow state
    function automatic axis_pkg::axis_meta_t predict_meta(input axis_pkg::axis_meta_t m);
        axis_pkg::axis_meta_t      r;
        logic [1:0]                func;
        logic [8:0]                idx;
        func = m.tuser.rss_entropy[11:10];
        idx  = {func, m.tuser.rss_entropy[6:0]};
        r    = m;
        r.tuser.rss_enable = 1'b1;
        if (m.tuser.rss_enable) begin
            r.tuser.rss_entropy = shadow_base[func] + shadow_table[idx];
        end else begin
            r.tuser.rss_entropy = shadow_base[func];
        end
        return r;
    endfunction

    // ========================================================================
    // Shadow registers
    // ========================================================================

    initial begin
        errors  = 0;
        pending = 0;
        rst_d   = 1'b0;
        stalled = 1'b0;
        for (int i = 0; i < 4; i++) begin
            shadow_base[i] = '0;
        end
    end

    always @(posedge core_clk) begin
        if (reg_wr && !rst) begin
            if (reg_addr < 10'd4) begin
                shadow_base[reg_addr[1:0]] = reg_wdata[11:0];
            end else if (reg_addr >= 10'd512) begin
                shadow_table[reg_addr[8:0]] = reg_wdata[11:0];
            end
        end
    end

    // ========================================================================
    // Output comparison and input capture
    // ========================================================================

    always @(posedge core_clk) begin
        axis_pkg::axis_meta_t exp_meta;
        logic                 exp_ready;
        if (rst_d && out_valid !== 1'b0) begin
            errors++;
            $display("out_valid high during or right after reset");
        end
        // Input side stalls only with both stages full and the sink busy
        exp_ready = !(meta_q.size() >= 2 && !out_ready);
        if (!rst && in_ready !== exp_ready) begin
            errors++;
            $display("CHECK FAILED %s in_ready expected %b actual %b",
                     test_name(test_id), exp_ready, in_ready);
        end
        if (stalled && !rst && (out_data != held_data || out_keep != held_keep
                || out_meta != held_meta || !out_valid)) begin
            errors++;
            $display("Output beat changed while stalled in test %s", test_name(test_id));
        end
        if (out_valid && out_ready && !rst) begin
            if (meta_q.size() == 0) begin
                errors++;
                $display("Output beat in test %s with no matching input beat",
                         test_name(test_id));
            end else begin
                exp_meta = predict_meta(meta_q.pop_front());
                if (out_meta != exp_meta) begin
                    errors++;
                    $display("CHECK FAILED %s meta expected %h actual %h",
                             test_name(test_id), exp_meta, out_meta);
                end
                if (out_data != data_q[0]) begin
                    errors++;
                    $display("CHECK FAILED %s data expected %h actual %h",
                             test_name(test_id), data_q[0], out_data);
                end
                if (out_keep != keep_q[0]) begin
                    errors++;
                    $display("CHECK FAILED %s keep expected %h actual %h",
                             test_name(test_id), keep_q[0], out_keep);
                end
                void'(data_q.pop_front());
                void'(keep_q.pop_front());
            end
        end
        if (in_valid && in_ready && !rst) begin
            data_q.push_back(in_data);
            keep_q.push_back(in_keep);
            meta_q.push_back(in_meta);
        end
        stalled   = out_valid && !out_ready && !rst;
        held_data = out_data;
        held_keep = out_keep;
        held_meta = out_meta;
        rst_d     = rst;
        pending   = meta_q.size();
    end

endmodule : hash2qid_checker

// ==== test/hash2qid_tb.sv ====
`timescale 1ns/1ps

module hash2qid_tb;

    localparam int DW          = 8;
    localparam int CYCLE_LIMIT = 20000;

    logic                    core_clk;
    logic                    rst;
    logic                    reg_wr;
    hash2qid_pkg::reg_addr_t reg_addr;
    hash2qid_pkg::reg_data_t reg_wdata;
    logic                    in_valid;
    logic                    in_ready;
    logic [DW*8-1:0]         in_data;
    logic [DW-1:0]           in_keep;
    axis_pkg::axis_meta_t    in_meta;
    logic                    out_valid;
    logic                    out_ready;
    logic [DW*8-1:0]         out_data;
    logic [DW-1:0]           out_keep;
    axis_pkg::axis_meta_t    out_meta;
    int                      test_id;
    int                      errors;
    int                      pending;
    int                      cycles;
    logic                    bp_mode;
    logic [31:0]             stim_seed;
    logic [31:0]             bp_seed;

    hash2qid #(
        .DATA_BYTE_WID (DW)
    ) dut0 (
        .core_clk, .rst, .reg_wr, .reg_addr, .reg_wdata,
        .in_valid, .in_ready, .in_data, .in_keep, .in_meta,
        .out_valid, .out_ready, .out_data, .out_keep, .out_meta
    );

    hash2qid_checker #(
        .DATA_BYTE_WID (DW)
    ) checker0 (
        .core_clk, .rst, .test_id, .reg_wr, .reg_addr, .reg_wdata,
        .in_valid, .in_ready, .in_data, .in_keep, .in_meta,
        .out_valid, .out_ready, .out_data, .out_keep, .out_meta,
        .errors, .pending
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    always #4 core_clk = ~core_clk;

    // Run limit
    always @(posedge core_clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d beats still in flight", cycles, pending);
            $display("Testbench failed");
            $finish;
        end
    end

    // Random or steady sink
    always @(posedge core_clk) begin
        #1;
        bp_seed   = lcg_next(bp_seed);
        out_ready = bp_mode ? bp_seed[17] : 1'b1;
    end

    // ========================================================================
    // Stimulus tasks
    // ========================================================================

    task automatic write_reg(input hash2qid_pkg::reg_addr_t addr, input logic [11:0] val);
        @(posedge core_clk);
        #1;
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = {20'd0, val};
        @(posedge core_clk);
        #1;
        reg_wr = 1'b0;
    endtask

    // Reference layout: inverted function number and inverted entry
    task automatic program_all();
        logic [1:0] nt;
        logic [6:0] nj;
        for (int t = 0; t < 4; t++) begin
            nt = ~2'(t);
            write_reg(10'(t), {nt, 10'd0});
            for (int j = 0; j < 128; j++) begin
                nj = ~7'(j);
                write_reg(10'(512 + t * 128 + j), {2'b00, nt, 1'b0, nj});
            end
        end
    endtask

    task automatic reprogram_some();
        for (int t = 0; t < 4; t++) begin
            stim_seed = lcg_next(stim_seed);
            write_reg(10'(t), stim_seed[27:16]);
        end
        for (int k = 0; k < 32; k++) begin
            stim_seed = lcg_next(stim_seed);
            write_reg({1'b1, stim_seed[24:16]}, stim_seed[11:0]);
        end
    endtask

    // Mode 0 RSS off, 1 RSS on, 2 mixed
    task automatic send_stream(input int n, input int mode);
        int pkt_left;
        pkt_left = 0;
        for (int i = 0; i < n; i++) begin
            if (pkt_left == 0) begin
                stim_seed = lcg_next(stim_seed);
                pkt_left  = 1 + int'(stim_seed[18:16]);
            end
            stim_seed = lcg_next(stim_seed);
            in_data[31:0]  = stim_seed;
            stim_seed = lcg_next(stim_seed);
            in_data[63:32] = stim_seed;
            stim_seed = lcg_next(stim_seed);
            in_keep                    = stim_seed[23:16];
            in_meta.tid                = stim_seed[27:24];
            in_meta.tdest              = stim_seed[31:28];
            in_meta.tuser.rss_entropy  = stim_seed[11:0];
            in_meta.tuser.rss_enable   = (mode == 2) ? stim_seed[12] : (mode == 1);
            in_meta.tlast              = (pkt_left == 1);
            in_valid = 1'b1;
            pkt_left--;
            do begin
                @(posedge core_clk);
            end while (!in_ready);
            #1;
        end
        in_valid = 1'b0;
        while (pending != 0) begin
            @(posedge core_clk);
            #1;
        end
        repeat (4) @(posedge core_clk);
        #1;
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        core_clk  = 1'b0;
        rst       = 1'b1;
        reg_wr    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        in_valid  = 1'b0;
        in_data   = '0;
        in_keep   = '0;
        in_meta   = '0;
        out_ready = 1'b1;
        bp_mode   = 1'b0;
        test_id   = 0;
        cycles    = 0;
        stim_seed = 32'h2b1f;
        bp_seed   = lcg_next(32'h2b1f);

        repeat (8) @(posedge core_clk);
        #1;
        rst = 1'b0;
        repeat (4) @(posedge core_clk);
        #1;

        program_all();
        repeat (4) @(posedge core_clk);
        #1;

        test_id = 1;
        send_stream(256, 1);
        test_id = 2;
        send_stream(256, 0);
        test_id = 3;
        bp_mode = 1'b1;
        send_stream(256, 2);
        bp_mode = 1'b0;

        test_id = 4;
        reprogram_some();
        repeat (4) @(posedge core_clk);
        #1;
        send_stream(256, 2);

        repeat (8) @(posedge core_clk);
        #1;
        if (pending != 0) begin
            $display("%0d input beats never came out of the DUT", pending);
        end
        $display("Errors: %0d, leftover beats: %0d", errors, pending);
        if (errors == 0 && pending == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : hash2qid_tb

// ==== filelist.f ====
source/axis_pkg.sv
source/hash2qid_pkg.sv
source/hash2qid_regs.sv
source/hash2qid_table.sv
source/hash2qid_lookup.sv
source/hash2qid_top.sv
test/hash2qid_checker.sv
test/hash2qid_tb.sv

// ==== Makefile ====
SOURCES := $(wildcard source/*.sv) $(wildcard test/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vhash2qid_tb: filelist.f $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module hash2qid_tb -f filelist.f

# Pass only when the pass line shows up in the simulation output
run: obj_dir/Vhash2qid_tb
	./obj_dir/Vhash2qid_tb | tee /dev/stderr | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir
